// ==== Makefile ====
TOP = hm_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -sv -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -sv \
		-f list.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/hm_apb_regs.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_apb_regs
  import hm_pkg::*;
(
  input  logic                   sys_clk_i,
  input  logic                   sys_rst_i,

  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`HM_APB_AW-1:0]  paddr_i,
  input  logic [`HM_DATA_W-1:0]  pwdata_i,
  output logic [`HM_DATA_W-1:0]  prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,

  hm_ctrl_if.regs                ctrl,

  output logic [`HM_BUF_AW-1:0]  buf_idx_o,
  input  logic [`HM_DATA_W-1:0]  buf_word_i,
  input  logic [`HM_BUF_AW:0]    buf_count_i,

  output logic                   irq_o
);

  hm_csr_e               csr_sel;
  logic                  access;
  logic                  wr_en;
  logic                  idle;
  logic                  reg_hit;
  logic                  in_buf;
  logic [`HM_APB_AW-1:0] buf_off;
  logic [`HM_DATA_W-1:0] rd_data;

  logic                  irq_en;
  logic [3:0]            stat_q;
  logic [3:0]            stat_clr;
  logic [3:0]            ev_vec;
  logic                  start_read_q;
  logic                  start_write_q;
  logic [`HM_ADDR_W-1:0] addr_q;
  logic [`HM_DATA_W-1:0] data_q;

  assign csr_sel = hm_csr_e'(paddr_i);
  assign access  = psel_i & penable_i;
  assign wr_en   = access & pwrite_i;
  assign idle    = (ctrl.state == HM_IDLE);

  // Buffer window of one word per 4 bytes
  assign buf_off   = paddr_i - `HM_BUF_BASE;
  assign in_buf    = (paddr_i >= `HM_BUF_BASE) &&
                     (buf_off[`HM_APB_AW-1:`HM_BUF_AW+2] == '0);
  assign buf_idx_o = buf_off[`HM_BUF_AW+1:2];

  always_comb begin
    rd_data = '0;
    reg_hit = 1'b1;
    case (csr_sel)
      HM_CSR_CTRL:     rd_data = `HM_DATA_W'(irq_en);
      HM_CSR_STAT:     rd_data = `HM_DATA_W'(stat_q);
      HM_CSR_ADDR_LO:  rd_data = addr_q[`HM_DATA_W-1:0];
      HM_CSR_ADDR_HI:  rd_data = addr_q[`HM_ADDR_W-1:`HM_DATA_W];
      HM_CSR_DATA:     rd_data = data_q;
      HM_CSR_STATE:    rd_data = `HM_DATA_W'(ctrl.state);
      HM_CSR_RD_COUNT: rd_data = `HM_DATA_W'(buf_count_i);
      default:         reg_hit = 1'b0;
    endcase
    if (in_buf) begin
      rd_data = buf_word_i;
    end
  end

  // No wait states
  assign pready_o  = access;
  assign pslverr_o = access & ~reg_hit & ~in_buf;
  assign prdata_o  = rd_data;

  assign ev_vec   = {ctrl.ev_wr_timeout, ctrl.ev_rx_timeout, ctrl.ev_tx_timeout, ctrl.ev_end};
  // W1C only honoured while idle
  assign stat_clr = (wr_en && csr_sel == HM_CSR_STAT && idle) ? pwdata_i[3:0] : 4'b0;

  always_ff @(posedge sys_clk_i) begin
    if (sys_rst_i) begin
      irq_en        <= 1'b0;
      stat_q        <= 4'b0;
      start_read_q  <= 1'b0;
      start_write_q <= 1'b0;
    end else begin
      start_read_q  <= wr_en && csr_sel == HM_CSR_CTRL && pwdata_i[1];
      start_write_q <= wr_en && csr_sel == HM_CSR_CTRL && pwdata_i[2];
      if (wr_en && csr_sel == HM_CSR_CTRL && idle) begin
        irq_en <= pwdata_i[0];
      end
      // A new event beats a clear in the same cycle
      stat_q <= (stat_q & ~stat_clr) | ev_vec;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (wr_en) begin
      case (csr_sel)
        HM_CSR_ADDR_LO: addr_q[`HM_DATA_W-1:0] <= pwdata_i;
        HM_CSR_ADDR_HI: addr_q[`HM_ADDR_W-1:`HM_DATA_W] <= pwdata_i;
        HM_CSR_DATA:    data_q <= pwdata_i;
        default: ;
      endcase
    end
  end

  assign ctrl.start_read  = start_read_q;
  assign ctrl.start_write = start_write_q;
  assign ctrl.addr        = addr_q;
  assign ctrl.data        = data_q;

  assign irq_o = irq_en & (|stat_q);

endmodule

// ==== hw/hm_ctrl_if.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

interface hm_ctrl_if
  import hm_pkg::*;
();

  // Commands from the register block
  logic                  start_read;
  logic                  start_write;
  logic [`HM_ADDR_W-1:0] addr;
  logic [`HM_DATA_W-1:0] data;

  // Status back from the state machine
  hm_state_e             state;
  logic                  ev_end;
  logic                  ev_tx_timeout;
  logic                  ev_rx_timeout;
  logic                  ev_wr_timeout;

  modport regs (
    output start_read, start_write, addr, data,
    input  state, ev_end, ev_tx_timeout, ev_rx_timeout, ev_wr_timeout
  );

  modport fsm (
    input  start_read, start_write, addr, data,
    output state, ev_end, ev_tx_timeout, ev_rx_timeout, ev_wr_timeout
  );

endinterface

// ==== hw/hm_fsm.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_fsm
  import hm_pkg::*;
(
  input  logic                   sys_clk_i,
  input  logic                   sys_rst_i,

  hm_ctrl_if.fsm                 ctrl,

  output logic                   run_o,
  input  logic                   expired_i,

  output logic                   req_valid_o,
  output logic                   req_write_o,
  output logic [`HM_ADDR_W-1:0]  req_addr_o,
  output logic [`HM_DATA_W-1:0]  req_data_o,
  input  logic                   req_ready_i,

  input  logic                   resp_valid_i,
  input  logic                   resp_last_i,

  output logic                   buf_clear_o,
  output logic                   buf_push_o
);

  hm_state_e state_q;
  logic      idle;
  logic      ev_end_q;
  logic      ev_tx_q;
  logic      ev_rx_q;
  logic      ev_wr_q;

  assign idle = (state_q == HM_IDLE);

  always_ff @(posedge sys_clk_i) begin
    if (sys_rst_i) begin
      state_q     <= HM_IDLE;
      req_valid_o <= 1'b0;
      ev_end_q    <= 1'b0;
      ev_tx_q     <= 1'b0;
      ev_rx_q     <= 1'b0;
      ev_wr_q     <= 1'b0;
    end else begin
      ev_end_q <= 1'b0;
      ev_tx_q  <= 1'b0;
      ev_rx_q  <= 1'b0;
      ev_wr_q  <= 1'b0;
      case (state_q)
        HM_IDLE: begin
          // Read wins over write
          if (ctrl.start_read) begin
            state_q     <= HM_SEND;
            req_valid_o <= 1'b1;
          end else if (ctrl.start_write) begin
            state_q     <= HM_WRITE;
            req_valid_o <= 1'b1;
          end
        end
        HM_SEND: begin
          if (expired_i) begin
            state_q     <= HM_IDLE;
            req_valid_o <= 1'b0;
            ev_tx_q     <= 1'b1;
          end else if (req_ready_i) begin
            state_q     <= HM_RECV;
            req_valid_o <= 1'b0;
          end
        end
        HM_RECV: begin
          if (expired_i) begin
            state_q <= HM_IDLE;
            ev_rx_q <= 1'b1;
          end else if (resp_valid_i && resp_last_i) begin
            state_q  <= HM_IDLE;
            ev_end_q <= 1'b1;
          end
        end
        HM_WRITE: begin
          // A write always reports end, even on timeout
          if (expired_i || req_ready_i) begin
            state_q     <= HM_IDLE;
            req_valid_o <= 1'b0;
            ev_end_q    <= 1'b1;
            ev_wr_q     <= expired_i;
          end
        end
        default: state_q <= HM_IDLE;
      endcase
    end
  end

  // Request payload latched when an operation starts
  always_ff @(posedge sys_clk_i) begin
    if (idle && (ctrl.start_read || ctrl.start_write)) begin
      req_write_o <= ~ctrl.start_read;
      req_data_o  <= ctrl.data;
      if (ctrl.start_read) begin
        req_addr_o <= {ctrl.addr[`HM_ADDR_W-1:`HM_PAGE_BITS], {`HM_PAGE_BITS{1'b0}}};
      end else begin
        req_addr_o <= ctrl.addr;
      end
    end
  end

  assign run_o       = ~idle;
  assign buf_clear_o = idle & ctrl.start_read;
  assign buf_push_o  = (state_q == HM_RECV) & resp_valid_i & ~expired_i;

  assign ctrl.state         = state_q;
  assign ctrl.ev_end        = ev_end_q;
  assign ctrl.ev_tx_timeout = ev_tx_q;
  assign ctrl.ev_rx_timeout = ev_rx_q;
  assign ctrl.ev_wr_timeout = ev_wr_q;

endmodule

// ==== hw/hm_params.svh ====
`ifndef HM_PARAMS_SVH
`define HM_PARAMS_SVH

// Host side widths
`define HM_ADDR_W 64
`define HM_DATA_W 32

// Read requests are page aligned
`define HM_PAGE_BITS 12

// APB register space
`define HM_APB_AW 8

// Read completion buffer
`define HM_BUF_DEPTH 16
`define HM_BUF_AW 4
`define HM_BUF_BASE 8'h40

// Per-operation watchdog
`define HM_TIMER_W 16
`define HM_TIMEOUT_CYCLES 200

`endif

// ==== hw/hm_pkg.sv ====
`include "hm_params.svh"

package hm_pkg;

  // Operation state shared with the register block for readback
  typedef enum logic [1:0] {
    HM_IDLE  = 2'd0,
    HM_SEND  = 2'd1,
    HM_RECV  = 2'd2,
    HM_WRITE = 2'd3
  } hm_state_e;

  // APB byte offsets
  typedef enum logic [`HM_APB_AW-1:0] {
    HM_CSR_CTRL     = 8'h00,
    HM_CSR_STAT     = 8'h04,
    HM_CSR_ADDR_LO  = 8'h08,
    HM_CSR_ADDR_HI  = 8'h0C,
    HM_CSR_DATA     = 8'h10,
    HM_CSR_STATE    = 8'h14,
    HM_CSR_RD_COUNT = 8'h18
  } hm_csr_e;

endpackage

// ==== hw/hm_read_buf.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_read_buf (
  input  logic                  sys_clk_i,
  input  logic                  sys_rst_i,

  input  logic                  clear_i,
  input  logic                  push_i,
  input  logic [`HM_DATA_W-1:0] push_data_i,

  input  logic [`HM_BUF_AW-1:0] rd_idx_i,
  output logic [`HM_DATA_W-1:0] rd_word_o,
  output logic [`HM_BUF_AW:0]   count_o
);

  logic [`HM_DATA_W-1:0] mem [`HM_BUF_DEPTH];
  logic [`HM_BUF_AW:0]   wr_ptr_q;
  logic                  full;

  // Extra beats are dropped once full
  assign full = (wr_ptr_q == (`HM_BUF_AW+1)'(`HM_BUF_DEPTH));

  always_ff @(posedge sys_clk_i) begin
    if (sys_rst_i || clear_i) begin
      wr_ptr_q <= '0;
    end else if (push_i && !full) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (push_i && !full) begin
      mem[wr_ptr_q[`HM_BUF_AW-1:0]] <= push_data_i;
    end
  end

  assign rd_word_o = mem[rd_idx_i];
  assign count_o   = wr_ptr_q;

endmodule

// ==== hw/hm_timer.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_timer (
  input  logic sys_clk_i,
  input  logic sys_rst_i,
  input  logic run_i,
  output logic expired_o
);

  logic [`HM_TIMER_W-1:0] cnt_q;

  always_ff @(posedge sys_clk_i) begin
    if (sys_rst_i || !run_i) begin
      cnt_q     <= '0;
      expired_o <= 1'b0;
    end else if (cnt_q == `HM_TIMER_W'(`HM_TIMEOUT_CYCLES - 1)) begin
      // Wrap and flag once per period
      cnt_q     <= '0;
      expired_o <= 1'b1;
    end else begin
      cnt_q     <= cnt_q + 1'b1;
      expired_o <= 1'b0;
    end
  end

endmodule

// ==== hw/hm_top.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_top (
  input  logic                  sys_clk_i,
  input  logic                  sys_rst_i,

  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`HM_APB_AW-1:0] paddr_i,
  input  logic [`HM_DATA_W-1:0] pwdata_i,
  output logic [`HM_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,

  output logic                  req_valid_o,
  output logic                  req_write_o,
  output logic [`HM_ADDR_W-1:0] req_addr_o,
  output logic [`HM_DATA_W-1:0] req_data_o,
  input  logic                  req_ready_i,

  input  logic                  resp_valid_i,
  input  logic                  resp_last_i,
  input  logic [`HM_DATA_W-1:0] resp_data_i,

  output logic                  irq_o
);

  logic                  run;
  logic                  expired;
  logic                  buf_clear;
  logic                  buf_push;
  logic [`HM_BUF_AW-1:0] buf_idx;
  logic [`HM_DATA_W-1:0] buf_word;
  logic [`HM_BUF_AW:0]   buf_count;

  hm_ctrl_if ctrl ();

  hm_apb_regs u_regs (
    .sys_clk_i   (sys_clk_i),
    .sys_rst_i   (sys_rst_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .ctrl        (ctrl.regs),
    .buf_idx_o   (buf_idx),
    .buf_word_i  (buf_word),
    .buf_count_i (buf_count),
    .irq_o       (irq_o)
  );

  hm_fsm u_fsm (
    .sys_clk_i    (sys_clk_i),
    .sys_rst_i    (sys_rst_i),
    .ctrl         (ctrl.fsm),
    .run_o        (run),
    .expired_i    (expired),
    .req_valid_o  (req_valid_o),
    .req_write_o  (req_write_o),
    .req_addr_o   (req_addr_o),
    .req_data_o   (req_data_o),
    .req_ready_i  (req_ready_i),
    .resp_valid_i (resp_valid_i),
    .resp_last_i  (resp_last_i),
    .buf_clear_o  (buf_clear),
    .buf_push_o   (buf_push)
  );

  hm_timer u_timer (
    .sys_clk_i (sys_clk_i),
    .sys_rst_i (sys_rst_i),
    .run_i     (run),
    .expired_o (expired)
  );

  hm_read_buf u_buf (
    .sys_clk_i   (sys_clk_i),
    .sys_rst_i   (sys_rst_i),
    .clear_i     (buf_clear),
    .push_i      (buf_push),
    .push_data_i (resp_data_i),
    .rd_idx_i    (buf_idx),
    .rd_word_o   (buf_word),
    .count_o     (buf_count)
  );

endmodule

// ==== list.f ====
+incdir+hw
hw/hm_pkg.sv
hw/hm_ctrl_if.sv
hw/hm_apb_regs.sv
hw/hm_fsm.sv
hw/hm_timer.sv
hw/hm_read_buf.sv
hw/hm_top.sv
sim/hm_checker.sv
sim/hm_tb.sv

// ==== sim/hm_checker.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_checker (
  input logic                  sys_clk_i,
  input logic                  sys_rst_i,
  input logic                  req_valid_i,
  input logic                  req_ready_i,
  input logic                  req_write_i,
  input logic [`HM_ADDR_W-1:0] req_addr_i,
  input logic [`HM_DATA_W-1:0] req_data_i,
  input logic                  pready_i,
  input logic                  pslverr_i,
  input logic                  irq_i,
  input logic                  irq_en_i,
  input logic                  expired_i
);

  int fail_count = 0;

  // Timer abort may drop a pending request
  a_req_hold: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
    req_valid_i && !req_ready_i && !expired_i |=>
      req_valid_i && $stable(req_addr_i) && $stable(req_data_i) && $stable(req_write_i))
    else begin
      fail_count++;
      $error("link request dropped or changed before ready");
    end

  a_slverr_ready: assert property (@(posedge sys_clk_i) pslverr_i |-> pready_i)
    else begin
      fail_count++;
      $error("pslverr_o high without pready_o");
    end

  a_reset_valid: assert property (@(posedge sys_clk_i) sys_rst_i |=> !req_valid_i)
    else begin
      fail_count++;
      $error("req_valid_o high after reset");
    end

  a_irq_enable: assert property (@(posedge sys_clk_i) disable iff (sys_rst_i)
    !irq_en_i |-> !irq_i)
    else begin
      fail_count++;
      $error("irq_o high while interrupts disabled");
    end

endmodule

bind hm_top hm_checker u_checker (
  .sys_clk_i   (sys_clk_i),
  .sys_rst_i   (sys_rst_i),
  .req_valid_i (req_valid_o),
  .req_ready_i (req_ready_i),
  .req_write_i (req_write_o),
  .req_addr_i  (req_addr_o),
  .req_data_i  (req_data_o),
  .pready_i    (pready_o),
  .pslverr_i   (pslverr_o),
  .irq_i       (irq_o),
  .irq_en_i    (u_regs.irq_en),
  .expired_i   (expired)
);

// ==== sim/hm_tb.sv ====
`timescale 1ns/1ps
`include "hm_params.svh"

module hm_tb
  import hm_pkg::*;
();

  logic                  sys_clk;
  logic                  sys_rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`HM_APB_AW-1:0] paddr;
  logic [`HM_DATA_W-1:0] pwdata;
  logic [`HM_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  req_valid;
  logic                  req_write;
  logic [`HM_ADDR_W-1:0] req_addr;
  logic [`HM_DATA_W-1:0] req_data;
  logic                  req_ready;
  logic                  resp_valid;
  logic                  resp_last;
  logic [`HM_DATA_W-1:0] resp_data;
  logic                  irq;

  int                    errors;
  logic [31:0]           lfsr;
  logic                  last_slverr;
  logic                  seen_write;
  logic [`HM_ADDR_W-1:0] seen_addr;
  logic [`HM_DATA_W-1:0] seen_data;
  logic [`HM_DATA_W-1:0] beat_data [`HM_BUF_DEPTH];

  hm_top uut (
    .sys_clk_i    (sys_clk),
    .sys_rst_i    (sys_rst),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .req_valid_o  (req_valid),
    .req_write_o  (req_write),
    .req_addr_o   (req_addr),
    .req_data_o   (req_data),
    .req_ready_i  (req_ready),
    .resp_valid_i (resp_valid),
    .resp_last_i  (resp_last),
    .resp_data_i  (resp_data),
    .irq_o        (irq)
  );

  initial sys_clk = 1'b0;
  always #2 sys_clk = ~sys_clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH at %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    next_cycle();
    penable = 1'b1;
    #1;
    check_value("pready_o", 1, pready);
    last_slverr = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] a, output logic [31:0] d);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    next_cycle();
    penable = 1'b1;
    #1;
    check_value("pready_o", 1, pready);
    last_slverr = pslverr;
    d = prdata;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Link model accepts after ready_delay cycles and then returns beats words
  task automatic serve_link(input int ready_delay, input int beats);
    int          n;
    int          i;
    logic [31:0] w;
    n = 0;
    while (!req_valid && n < 50) begin
      next_cycle();
      n++;
    end
    if (!req_valid) begin
      errors++;
      $display("ERROR at %0d ns: no link request seen within 50 cycles", $time);
      return;
    end
    seen_write = req_write;
    seen_addr  = req_addr;
    seen_data  = req_data;
    for (i = 0; i < ready_delay; i++) begin
      next_cycle();
      check_value("req_valid_o", 1, req_valid);
      check_value("req_write_o", seen_write, req_write);
      check_value("req_addr_o", seen_addr, req_addr);
      check_value("req_data_o", seen_data, req_data);
    end
    req_ready = 1'b1;
    next_cycle();
    req_ready = 1'b0;
    for (i = 0; i < beats; i++) begin
      rand_bits(32, w);
      beat_data[i] = w;
      resp_valid   = 1'b1;
      resp_data    = w;
      resp_last    = (i == beats - 1);
      next_cycle();
    end
    resp_valid = 1'b0;
    resp_last  = 1'b0;
  endtask

  task automatic wait_stat(input logic [3:0] mask, output logic [31:0] val);
    int n;
    n = 0;
    apb_read(HM_CSR_STAT, val);
    while ((val[3:0] & mask) == 4'h0 && n < `HM_TIMEOUT_CYCLES) begin
      apb_read(HM_CSR_STAT, val);
      n++;
    end
    if ((val[3:0] & mask) == 4'h0) begin
      errors++;
      $display("ERROR at %0d ns: STAT bits %h never set", $time, mask);
    end
  endtask

  task automatic test_registers();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] v;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(32, c);
    apb_write(HM_CSR_ADDR_LO, a);
    apb_write(HM_CSR_ADDR_HI, b);
    apb_write(HM_CSR_DATA, c);
    apb_read(HM_CSR_ADDR_LO, v);
    check_value("ADDR_LO", a, v);
    check_value("pslverr_o", 0, last_slverr);
    apb_read(HM_CSR_ADDR_HI, v);
    check_value("ADDR_HI", b, v);
    apb_read(HM_CSR_DATA, v);
    check_value("DATA", c, v);
    apb_read(HM_CSR_STATE, v);
    check_value("STATE", HM_IDLE, v);
    // Hole between the registers and the buffer window
    apb_read(8'h30, v);
    check_value("pslverr_o", 1, last_slverr);
    apb_write(8'h30, a);
    check_value("pslverr_o", 1, last_slverr);
  endtask

  task automatic test_write_op();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] v;
    rand_bits(32, lo);
    rand_bits(32, hi);
    rand_bits(32, d);
    rand_bits(3, r);
    apb_write(HM_CSR_ADDR_LO, lo);
    apb_write(HM_CSR_ADDR_HI, hi);
    apb_write(HM_CSR_DATA, d);
    apb_write(HM_CSR_CTRL, 32'h5);
    serve_link(int'(r[2:0]), 0);
    check_value("req_write_o", 1, seen_write);
    check_value("req_addr_o", {hi, lo}, seen_addr);
    check_value("req_data_o", d, seen_data);
    wait_stat(4'h1, v);
    check_value("STAT", 32'h1, v);
    check_value("irq_o", 1, irq);
    apb_write(HM_CSR_STAT, 32'h1);
    apb_read(HM_CSR_STAT, v);
    check_value("STAT", 32'h0, v);
    check_value("irq_o", 0, irq);
  endtask

  task automatic test_read_op();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] dly;
    logic [31:0] len;
    logic [31:0] v;
    logic [63:0] page;
    int          burst;
    int          i;
    rand_bits(32, lo);
    rand_bits(32, hi);
    rand_bits(3, dly);
    rand_bits(4, len);
    burst = int'(len[3:0]) + 1;
    page  = {hi, lo} & ~((64'h1 << `HM_PAGE_BITS) - 64'h1);
    apb_write(HM_CSR_ADDR_LO, lo);
    apb_write(HM_CSR_ADDR_HI, hi);
    apb_write(HM_CSR_CTRL, 32'h3);
    serve_link(int'(dly[2:0]), burst);
    check_value("req_write_o", 0, seen_write);
    check_value("req_addr_o", page, seen_addr);
    wait_stat(4'h1, v);
    check_value("STAT", 32'h1, v);
    apb_read(HM_CSR_RD_COUNT, v);
    check_value("RD_COUNT", burst, v);
    for (i = 0; i < burst; i++) begin
      apb_read(`HM_BUF_BASE + 8'(4 * i), v);
      check_value($sformatf("buffer word %0d", i), beat_data[i], v);
    end
    apb_write(HM_CSR_STAT, 32'hF);
  endtask

  task automatic test_timeouts();
    logic [31:0] v;
    // Request never accepted
    apb_write(HM_CSR_CTRL, 32'h3);
    wait_stat(4'hF, v);
    check_value("STAT", 32'h2, v);
    check_value("req_valid_o", 0, req_valid);
    apb_read(HM_CSR_STATE, v);
    check_value("STATE", HM_IDLE, v);
    apb_write(HM_CSR_STAT, 32'hF);
    // No completion beats
    apb_write(HM_CSR_CTRL, 32'h3);
    serve_link(0, 0);
    wait_stat(4'hF, v);
    check_value("STAT", 32'h4, v);
    apb_read(HM_CSR_STATE, v);
    check_value("STATE", HM_IDLE, v);
    apb_write(HM_CSR_STAT, 32'hF);
    // Write never accepted still reports end
    apb_write(HM_CSR_CTRL, 32'h5);
    wait_stat(4'hF, v);
    check_value("STAT", 32'h9, v);
    check_value("req_valid_o", 0, req_valid);
    apb_read(HM_CSR_STATE, v);
    check_value("STATE", HM_IDLE, v);
    apb_write(HM_CSR_STAT, 32'hF);
  endtask

  task automatic test_busy_rules();
    logic [31:0] v;
    apb_write(HM_CSR_CTRL, 32'h5);
    serve_link(0, 0);
    wait_stat(4'h1, v);
    // Read left stalled in SEND
    apb_write(HM_CSR_CTRL, 32'h3);
    apb_write(HM_CSR_CTRL, 32'h4);
    apb_write(HM_CSR_STAT, 32'hF);
    apb_read(HM_CSR_STATE, v);
    check_value("STATE", HM_SEND, v);
    apb_read(HM_CSR_STAT, v);
    check_value("STAT", 32'h1, v);
    apb_read(HM_CSR_CTRL, v);
    check_value("CTRL", 32'h1, v);
    check_value("req_valid_o", 1, req_valid);
    check_value("req_write_o", 0, req_write);
    check_value("irq_o", 1, irq);
    wait_stat(4'h2, v);
    check_value("STAT", 32'h3, v);
    apb_write(HM_CSR_STAT, 32'hF);
    apb_read(HM_CSR_STAT, v);
    check_value("STAT", 32'h0, v);
  endtask

  initial begin
    sys_rst    = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    req_ready  = 1'b0;
    resp_valid = 1'b0;
    resp_last  = 1'b0;
    resp_data  = '0;
    errors     = 0;
    lfsr       = 32'h8ddc_8379;
    repeat (4) @(posedge sys_clk);
    #1;
    sys_rst = 1'b0;
    check_value("req_valid_o", 0, req_valid);
    check_value("irq_o", 0, irq);
    check_value("pready_o", 0, pready);
    check_value("pslverr_o", 0, pslverr);
    test_registers();
    test_write_op();
    test_read_op();
    test_timeouts();
    test_busy_rules();
    $display("Errors: testbench %0d, assertions %0d", errors, uut.u_checker.fail_count);
    if (errors == 0 && uut.u_checker.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Room for 20 full timeouts plus margin
  initial begin
    #(20 * `HM_TIMEOUT_CYCLES * 4 + 20000);
    $display("ERROR: watchdog expired at %0d ns, the run did not finish", $time);
    $display("Test failed");
    $finish;
  end

endmodule
